// ==== mwConsts.svh ====
`ifndef MW_CONSTS_SVH
`define MW_CONSTS_SVH

// number of cook time digits on the display
`define MW_DIGITS 4

// segments a to g of one display digit
`define MW_SEG_W 7

// clock cycles in one second for a 50 MHz board clock
`define MW_TICKS_PER_SEC 50000000

// how long the oven beeps and blinks once cooking is over, in seconds
`define MW_DONE_SECONDS 3

`endif

// ==== mwDisplayPkg.sv ====
`include "mwConsts.svh"

package mwDisplayPkg;

    typedef logic [3:0] bcdDigit; // one decimal digit 0 to 9

    // index 0 is the seconds ones digit and the top index is the leftmost one
    typedef bcdDigit [`MW_DIGITS-1:0] cookTimeT;

    typedef logic [`MW_SEG_W-1:0] segPattern; // segment a in bit 0, g in bit 6

endpackage

// ==== mwStatePkg.sv ====
package mwStatePkg;

    // main oven states
    typedef enum logic [1:0]
    {
        Idle,    // nothing entered, display shows 0000
        Entry,   // digits being entered or cooking paused
        Cooking, // counting down with the loads on unless the door is open
        Done     // beep and blink before returning to idle
    } ovenState;

endpackage

// ==== cookTime.sv ====
`timescale 1ns/1ns

`include "mwConsts.svh"

module cookTime
(
    input  logic                  t,
    input  logic                  est2,
    input  logic                  shiftIn,
    input  mwDisplayPkg::bcdDigit digitValue,
    input  logic                  clearTime,
    input  logic                  countDown,
    output mwDisplayPkg::cookTimeT digits,
    output logic                  timeZero
);

    mwDisplayPkg::cookTimeT decDigits; // time minus one second
    logic                   borrow;

    // plain decimal subtract, a zero digit borrows from the next one and wraps to 9
    always_comb
    begin
        borrow = 1'b1;
        for (int i = 0; i < `MW_DIGITS; i++)
        begin
            if (!borrow)
                decDigits[i] = digits[i];
            else if (digits[i] == 4'd0)
                decDigits[i] = 4'd9; // borrow moves on to the next digit
            else
            begin
                decDigits[i] = digits[i] - 4'd1;
                borrow = 1'b0;
            end
        end
    end

    always_ff @(posedge t or posedge est2)
    begin
        if (est2)
            digits <= '0;
        else if (clearTime)
            digits <= '0;
        else if (shiftIn)
            digits <= {digits[`MW_DIGITS-2:0], digitValue}; // leftmost digit drops out
        else if (countDown)
            digits <= decDigits;
    end

    assign timeZero = (digits == '0);

    // the controller issues at most one time command per cycle
    assert property (@(posedge t) disable iff (est2)
        $onehot0({shiftIn, clearTime, countDown}))
        else $error("cookTime: more than one time command in one cycle");

    // only valid keys are shifted in and the borrow never leaves a non-decimal digit
    for (genvar g = 0; g < `MW_DIGITS; g++)
    begin : digitRange
        assert property (@(posedge t) disable iff (est2) digits[g] <= 4'd9)
            else $error("cookTime: digit %0d holds %h", g, digits[g]);
    end

endmodule

// ==== ovenControl.sv ====
`timescale 1ns/1ns

`include "mwConsts.svh"

module ovenControl
#(
    parameter int TicksPerSec = `MW_TICKS_PER_SEC
)
(
    input  logic                  t,
    input  logic                  est2,
    input  logic                  digitKey,
    input  mwDisplayPkg::bcdDigit digitValue,
    input  logic                  startKey,
    input  logic                  cancelKey,
    input  logic                  door,
    input  logic                  timeZero,
    output logic                  shiftIn,
    output logic                  clearTime,
    output logic                  countDown,
    output logic                  blank,
    output logic                  motor,
    output logic                  heater,
    output logic                  light,
    output logic                  beep
);

    localparam int TickW = $clog2(TicksPerSec);
    localparam int DoneW = $clog2(`MW_DONE_SECONDS + 1);
    localparam int Half  = TicksPerSec / 2; // beep in the first half, blank in the second

    mwStatePkg::ovenState state;
    mwStatePkg::ovenState stateNext;
    logic [TickW-1:0]     tick;
    logic [TickW-1:0]     tickNext;
    logic [DoneW-1:0]     doneSec;
    logic [DoneW-1:0]     doneSecNext;
    logic                 secTick;
    logic                 digitOk;

    assign secTick = (tick == TickW'(TicksPerSec - 1)); // last cycle of a second
    assign digitOk = digitKey && (digitValue <= 4'd9);  // keys above 9 are dropped

    always_comb
    begin
        stateNext   = state;
        tickNext    = '0; // prescaler sits at zero outside cooking and done
        doneSecNext = '0;
        shiftIn     = 1'b0;
        clearTime   = 1'b0;
        countDown   = 1'b0;
        case (state)
            mwStatePkg::Idle:
            begin
                if (digitOk)
                begin
                    shiftIn   = 1'b1;
                    stateNext = mwStatePkg::Entry;
                end
            end
            mwStatePkg::Entry:
            begin
                if (digitOk)
                    shiftIn = 1'b1;
                else if (cancelKey)
                begin
                    clearTime = 1'b1; // second cancel throws the time away
                    stateNext = mwStatePkg::Idle;
                end
                else if (startKey && !door && !timeZero)
                    stateNext = mwStatePkg::Cooking;
            end
            mwStatePkg::Cooking:
            begin
                if (cancelKey)
                    stateNext = mwStatePkg::Entry; // pause and keep the remaining time
                else if (timeZero)
                    stateNext = mwStatePkg::Done;
                else if (door)
                    tickNext = tick; // count holds while the door is open
                else
                begin
                    tickNext  = secTick ? '0 : tick + TickW'(1);
                    countDown = secTick;
                end
            end
            mwStatePkg::Done:
            begin
                tickNext    = secTick ? '0 : tick + TickW'(1);
                doneSecNext = doneSec;
                if (secTick)
                begin
                    if (doneSec == DoneW'(`MW_DONE_SECONDS - 1))
                    begin
                        clearTime = 1'b1;
                        stateNext = mwStatePkg::Idle;
                    end
                    else
                        doneSecNext = doneSec + DoneW'(1);
                end
            end
        endcase
    end

    always_ff @(posedge t or posedge est2)
    begin
        if (est2)
        begin
            state   <= mwStatePkg::Idle;
            tick    <= '0;
            doneSec <= '0;
            motor   <= 1'b0;
            heater  <= 1'b0;
            light   <= 1'b0;
            beep    <= 1'b0;
        end
        else
        begin
            state   <= stateNext;
            tick    <= tickNext;
            doneSec <= doneSecNext;
            motor   <= (stateNext == mwStatePkg::Cooking) && !door; // door interlock
            heater  <= (stateNext == mwStatePkg::Cooking) && !door;
            light   <= door || (stateNext == mwStatePkg::Cooking);
            beep    <= (stateNext == mwStatePkg::Done) && (tickNext < TickW'(Half));
        end
    end

    assign blank = (state == mwStatePkg::Done) && !beep; // display off while the beep rests

    // an open door must switch the loads off by the next edge
    assert property (@(posedge t) disable iff (est2) door |=> !motor)
        else $error("ovenControl: motor still on after the door opened");

    assert property (@(posedge t) disable iff (est2) motor == heater)
        else $error("ovenControl: motor and heater disagree");

endmodule

// ==== segDisplay.sv ====
`timescale 1ns/1ns

module segDisplay
(
    input  mwDisplayPkg::cookTimeT  digits,
    input  logic                    blank,
    output mwDisplayPkg::segPattern seg0,
    output mwDisplayPkg::segPattern seg1,
    output mwDisplayPkg::segPattern seg2,
    output mwDisplayPkg::segPattern seg3
);

    // segment g is the top bit, a is bit 0
    function automatic mwDisplayPkg::segPattern segOf(input mwDisplayPkg::bcdDigit d);
        mwDisplayPkg::segPattern p;
        case (d)
            4'd0:    p = 7'b0111111;
            4'd1:    p = 7'b0000110;
            4'd2:    p = 7'b1011011;
            4'd3:    p = 7'b1001111;
            4'd4:    p = 7'b1100110;
            4'd5:    p = 7'b1101101;
            4'd6:    p = 7'b1111101;
            4'd7:    p = 7'b0000111;
            4'd8:    p = 7'b1111111;
            4'd9:    p = 7'b1101111;
            default: p = 7'b0000000; // not a decimal digit, show nothing
        endcase
        return p;
    endfunction

    assign seg0 = blank ? '0 : segOf(digits[0]); // seconds ones
    assign seg1 = blank ? '0 : segOf(digits[1]);
    assign seg2 = blank ? '0 : segOf(digits[2]);
    assign seg3 = blank ? '0 : segOf(digits[3]); // leftmost digit

endmodule

// ==== microwaveTop.sv ====
`timescale 1ns/1ns

`include "mwConsts.svh"

module microwaveTop
#(
    parameter int TicksPerSec = `MW_TICKS_PER_SEC
)
(
    input  logic                    t,
    input  logic                    est2,
    input  logic                    digitKey,
    input  mwDisplayPkg::bcdDigit   digitValue,
    input  logic                    startKey,
    input  logic                    cancelKey,
    input  logic                    door,
    output mwDisplayPkg::segPattern seg0,
    output mwDisplayPkg::segPattern seg1,
    output mwDisplayPkg::segPattern seg2,
    output mwDisplayPkg::segPattern seg3,
    output logic                    motor,
    output logic                    heater,
    output logic                    light,
    output logic                    beep
);

    logic                   shiftIn;
    logic                   clearTime;
    logic                   countDown;
    logic                   timeZero;
    logic                   blank;
    mwDisplayPkg::cookTimeT digits;

    ovenControl #(.TicksPerSec(TicksPerSec)) control
    (
        .t(t), .est2(est2), .digitKey(digitKey), .digitValue(digitValue),
        .startKey(startKey), .cancelKey(cancelKey), .door(door), .timeZero(timeZero),
        .shiftIn(shiftIn), .clearTime(clearTime), .countDown(countDown), .blank(blank),
        .motor(motor), .heater(heater), .light(light), .beep(beep)
    );

    cookTime timeRegs
    (
        .t(t), .est2(est2), .shiftIn(shiftIn), .digitValue(digitValue),
        .clearTime(clearTime), .countDown(countDown), .digits(digits), .timeZero(timeZero)
    );

    segDisplay display
    (
        .digits(digits), .blank(blank),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock
(
    output logic t,
    output logic est2
);

    initial
    begin
        t = 1'b0;
        forever #10 t = ~t; // 20 ns period
    end

    initial
    begin
        est2 = 1'b1;
        repeat (5) @(posedge t);
        est2 <= 1'b0; // released on the fifth rising edge
    end

endmodule

// ==== mwChecker.sv ====
`timescale 1ns/1ns

module mwChecker
(
    input  logic                    t,
    input  logic                    est2,
    input  logic                    door,
    input  mwDisplayPkg::segPattern seg0,
    input  mwDisplayPkg::segPattern seg1,
    input  mwDisplayPkg::segPattern seg2,
    input  mwDisplayPkg::segPattern seg3,
    input  logic                    motor,
    input  logic                    heater,
    input  logic                    light,
    input  logic                    beep,
    output int                      checks,
    output int                      valueErrors,
    output int                      otherErrors
);

    // segments a to g sit in bits 0 to 6, one entry per decimal digit
    localparam logic [6:0] SegOfDigit [10] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
                                               7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f};

    logic [15:0] expDigits; // leftmost digit in the top nibble
    logic        expMotor;
    logic [1:0]  expDone;   // 0 outside Done, 1 beeping, 2 blanked
    event        checkNow;
    int          requested;
    int          served;
    bit          doorLast;

    task automatic compareValue(input string name, input logic [6:0] got,
                                input logic [6:0] want);
        if (got !== want)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            valueErrors++;
        end
    endtask

    task automatic runCheck;
        mwDisplayPkg::segPattern shown [4];
        logic [3:0]              d;
        shown = '{seg0, seg1, seg2, seg3};
        checks++;
        for (int i = 0; i < 4; i++)
        begin
            d = expDigits[4*i +: 4];
            if (d > 4'd9)
            begin
                $display("the cases file asks for digit %h, which is not decimal", d);
                otherErrors++;
            end
            else
                compareValue($sformatf("seg%0d", i), shown[i],
                             (expDone == 2'd2) ? 7'h00 : SegOfDigit[d]);
        end
        compareValue("motor", {6'b0, motor}, {6'b0, expMotor});
        compareValue("heater", {6'b0, heater}, {6'b0, expMotor}); // both loads switch together
        compareValue("beep", {6'b0, beep}, {6'b0, expDone == 2'd1});
    endtask

    initial
    forever
    begin
        @(checkNow);
        requested++; // served at the next falling edge
    end

    always @(negedge t)
    begin
        if (!est2)
        begin
            if (door == doorLast) // light lags a door change by one cycle
                compareValue("light", {6'b0, light}, {6'b0, door || motor});
            if (beep && motor)
            begin
                $display("the oven beeped while the motor was running");
                otherErrors++;
            end
            if (requested != served)
                runCheck();
        end
        served   <= requested;
        doorLast <= door;
    end

endmodule

// ==== microwaveTb.sv ====
`timescale 1ns/1ns

module microwaveTb;

    logic                    t;
    logic                    est2;
    logic                    digitKey;
    mwDisplayPkg::bcdDigit   digitValue;
    logic                    startKey;
    logic                    cancelKey;
    logic                    door;
    mwDisplayPkg::segPattern seg0;
    mwDisplayPkg::segPattern seg1;
    mwDisplayPkg::segPattern seg2;
    mwDisplayPkg::segPattern seg3;
    logic                    motor;
    logic                    heater;
    logic                    light;
    logic                    beep;
    int                      checks;
    int                      valueErrors;
    int                      otherErrors;
    int                      caseErrors;
    int                      cycles;
    int                      limit; // sum of the waits plus a margin for reset and key edges

    string       actQ [$];
    logic [3:0]  argQ [$];
    int          waitQ [$];
    logic [15:0] digitsQ [$];
    logic        motorQ [$];
    logic [1:0]  doneQ [$];

    tbClock clockGen (.*);
    microwaveTop #(.TicksPerSec(4)) DUT (.*);
    mwChecker chk (.*);

    task automatic readCases;
        int          fd;
        string       line;
        string       act;
        logic [3:0]  arg;
        int          wt;
        logic [15:0] digs;
        logic        mot;
        logic [1:0]  dn;
        fd = $fopen("mwCases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open mwCases.txt");
            caseErrors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    if ($sscanf(line, "%s %h %d %h %h %h", act, arg, wt, digs, mot, dn) != 6)
                    begin
                        $display("cannot parse this line of mwCases.txt: %s", line);
                        caseErrors++;
                    end
                    else
                    begin
                        actQ.push_back(act);
                        argQ.push_back(arg);
                        waitQ.push_back(wt);
                        digitsQ.push_back(digs);
                        motorQ.push_back(mot);
                        doneQ.push_back(dn);
                        limit += wt;
                    end
                end
            end
            $fclose(fd);
        end
        limit += 100;
    endtask

    task automatic applyRecord(input int i);
        @(posedge t);
        if (actQ[i] == "digit")
        begin
            digitKey   <= 1'b1;
            digitValue <= argQ[i];
        end
        else if (actQ[i] == "start")
            startKey <= 1'b1;
        else if (actQ[i] == "cancel")
            cancelKey <= 1'b1;
        else if (actQ[i] == "door")
            door <= argQ[i][0]; // door is a level and stays until the next door record
        else if (actQ[i] != "wait")
        begin
            $display("unknown action %s in record %0d", actQ[i], i);
            caseErrors++;
        end
        @(posedge t); // the DUT takes the key on this edge
        digitKey  <= 1'b0;
        startKey  <= 1'b0;
        cancelKey <= 1'b0;
        repeat (waitQ[i]) @(posedge t);
        chk.expDigits = digitsQ[i];
        chk.expMotor  = motorQ[i];
        chk.expDone   = doneQ[i];
        -> chk.checkNow;
    endtask

    always @(posedge t)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("the run hit its limit of %0d cycles without finishing", limit);
            $display("checks %0d, value errors %0d, other errors %0d, case file errors %0d",
                     checks, valueErrors, otherErrors, caseErrors);
            $display("Some tests failed");
            $finish;
        end
    end

    initial
    begin
        digitKey   = 1'b0;
        digitValue = '0;
        startKey   = 1'b0;
        cancelKey  = 1'b0;
        door       = 1'b0;
        readCases();
        @(negedge est2);
        for (int i = 0; i < actQ.size(); i++)
            applyRecord(i);
        repeat (2) @(posedge t); // let the last check land
        if (checks != actQ.size())
            $display("only %0d of %0d checks ran", checks, actQ.size());
        $display("checks %0d, value errors %0d, other errors %0d, case file errors %0d",
                 checks, valueErrors, otherErrors, caseErrors);
        if (valueErrors + otherErrors + caseErrors == 0 && checks == actQ.size()
            && actQ.size() > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== mwCases.txt ====
# action, argument in hex, wait in cycles, expected digits d3d2d1d0, motor, done
# done is 0 outside Done, 1 while the oven beeps and 2 while the display is blanked
digit  1 0  0001 0 0
digit  2 0  0012 0 0
digit  3 0  0123 0 0
digit  4 0  1234 0 0
digit  5 0  2345 0 0
digit  a 0  2345 0 0
cancel 0 0  0000 0 0
start  0 0  0000 0 0
digit  1 0  0001 0 0
digit  2 0  0012 0 0
door   1 0  0012 0 0
start  0 0  0012 0 0
door   0 0  0012 0 0
start  0 12 0009 1 0
door   1 0  0009 0 0
wait   0 8  0009 0 0
door   0 2  0008 1 0
cancel 0 8  0008 0 0
start  0 0  0008 1 0
cancel 0 0  0008 0 0
cancel 0 0  0000 0 0
digit  2 0  0002 0 0
start  0 8  0000 1 0
wait   0 0  0000 0 1
wait   0 0  0000 0 2
wait   0 6  0000 0 2
wait   0 0  0000 0 0
digit  7 0  0007 0 0

// ==== src.f ====
+incdir+.
mwDisplayPkg.sv
mwStatePkg.sv
cookTime.sv
ovenControl.sv
segDisplay.sv
microwaveTop.sv
tbClock.sv
mwChecker.sv
microwaveTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module microwaveTb -f src.f \
    && ./obj_dir/VmicrowaveTb | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }
